//--- sim.f
design/intra_geom_pkg.sv
design/intra_mode_pkg.sv
design/sample_delay.sv
design/intra_pred_4x4.sv
design/recon_clip.sv
design/intra_recon_top.sv
dv/intra_recon_props.sv
dv/tb_intra_recon.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator and runs it
# exit status 0 only when the log carries no failure

set -u
cd "$(dirname "$0")"

TOP=tb_intra_recon
OBJ=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module "$TOP" --Mdir "$OBJ" -f sim.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed with status $status"
	exit 1
fi

"./$OBJ/V$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "Result: FAILED" "$SIM_LOG"; then
	echo "simulation reported failure"
	exit 1
fi

# a failed bound assertion stops the run before any result line
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if ! grep -q "Result: PASSED" "$SIM_LOG"; then
	echo "no result line found in $SIM_LOG"
	exit 1
fi

echo "simulation passed"
exit 0

//--- dv/tb_intra_recon.sv
`timescale 1ns/1ps

module tb_intra_recon;

	import intra_geom_pkg::*;
	import intra_mode_pkg::*;

	localparam int BIT_DEPTH    = 8;
	localparam int RES_W        = BIT_DEPTH + 1;
	localparam int BLK_W        = NUM_SAMPLES * BIT_DEPTH;
	localparam int MAX_SAMPLE   = (1 << BIT_DEPTH) - 1;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES   = 2000; // ~310 blocks plus drain gaps and reset

	// residual patterns
	localparam int RES_ZERO = 0;
	localparam int RES_RAND = 1;
	localparam int RES_MAX  = 2;
	localparam int RES_MIN  = 3;

	logic                         clk;
	logic                         arst_n;
	logic                         i_valid;
	mode_t                        i_mode;
	logic                         i_is_inter;
	logic [TB_SIZE*BIT_DEPTH-1:0] i_above;
	logic [TB_SIZE*BIT_DEPTH-1:0] i_left;
	logic [BIT_DEPTH-1:0]         i_top_right;
	logic [BIT_DEPTH-1:0]         i_bottom_left;
	logic [NUM_SAMPLES*RES_W-1:0] i_residuals;
	logic [BLK_W-1:0]             i_pred_inter;
	logic                         o_valid;
	logic [BLK_W-1:0]             o_recon;

	logic [BLK_W-1:0] exp_q[$];
	string            name_q[$];
	logic [BLK_W-1:0] exp_blk;
	string            exp_name;
	int               errors  = 0;
	int               sent    = 0;
	int               checked = 0;
	int               cycles  = 0;

	intra_recon_top #(
		.BIT_DEPTH(BIT_DEPTH)
	) u_intra_recon_top (
		.clk          (clk),
		.arst_n       (arst_n),
		.i_valid      (i_valid),
		.i_mode       (i_mode),
		.i_is_inter   (i_is_inter),
		.i_above      (i_above),
		.i_left       (i_left),
		.i_top_right  (i_top_right),
		.i_bottom_left(i_bottom_left),
		.i_residuals  (i_residuals),
		.i_pred_inter (i_pred_inter),
		.o_valid      (o_valid),
		.o_recon      (o_recon)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reference: prediction rules, then residual add and clip
	function automatic logic [BLK_W-1:0] expected_block(input logic [5:0] mode,
			input logic is_inter, input logic [TB_SIZE*BIT_DEPTH-1:0] above,
			input logic [TB_SIZE*BIT_DEPTH-1:0] left, input logic [BIT_DEPTH-1:0] tr,
			input logic [BIT_DEPTH-1:0] bl, input logic [NUM_SAMPLES*RES_W-1:0] res,
			input logic [BLK_W-1:0] inter);
		logic [BLK_W-1:0] blk;
		int dc;
		int a;
		int l;
		int p;
		int s;
		int idx;

		dc = 4;
		for (int i = 0; i < TB_SIZE; i++)
			dc += int'(above[i*BIT_DEPTH +: BIT_DEPTH]) + int'(left[i*BIT_DEPTH +: BIT_DEPTH]);
		dc = dc / 8;
		for (int y = 0; y < TB_SIZE; y++) begin
			for (int x = 0; x < TB_SIZE; x++) begin
				idx = y*TB_SIZE + x;
				a   = int'(above[x*BIT_DEPTH +: BIT_DEPTH]);
				l   = int'(left[y*BIT_DEPTH +: BIT_DEPTH]);
				if (is_inter)
					p = int'(inter[idx*BIT_DEPTH +: BIT_DEPTH]);
				else if (mode == MODE_PLANAR)
					p = ((3-x)*l + (x+1)*int'(tr) + (3-y)*a + (y+1)*int'(bl) + 4) / 8;
				else if (mode == MODE_HOR)
					p = l;
				else if (mode == MODE_VER)
					p = a;
				else
					p = dc; // dc and every unlisted code
				s = p + int'($signed(res[idx*RES_W +: RES_W]));
				if (s < 0)
					s = 0;
				if (s > MAX_SAMPLE)
					s = MAX_SAMPLE;
				blk[idx*BIT_DEPTH +: BIT_DEPTH] = BIT_DEPTH'(s);
			end
		end
		return blk;
	endfunction

	function automatic mode_t random_mode();
		case ($urandom % 5)
			0:       return MODE_PLANAR;
			1:       return MODE_DC;
			2:       return MODE_HOR;
			3:       return MODE_VER;
			default: return mode_t'($urandom);
		endcase
	endfunction

	task automatic send_block(input string name, input mode_t mode, input logic is_inter,
			input int res_kind);
		@(negedge clk);
		i_valid       = 1'b1;
		i_mode        = mode;
		i_is_inter    = is_inter;
		i_top_right   = BIT_DEPTH'($urandom);
		i_bottom_left = BIT_DEPTH'($urandom);
		for (int i = 0; i < TB_SIZE; i++) begin
			i_above[i*BIT_DEPTH +: BIT_DEPTH] = BIT_DEPTH'($urandom);
			i_left[i*BIT_DEPTH +: BIT_DEPTH]  = BIT_DEPTH'($urandom);
		end
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			i_pred_inter[i*BIT_DEPTH +: BIT_DEPTH] = BIT_DEPTH'($urandom);
			case (res_kind)
				RES_RAND: i_residuals[i*RES_W +: RES_W] = RES_W'($urandom);
				RES_MAX:  i_residuals[i*RES_W +: RES_W] = RES_W'(MAX_SAMPLE);
				RES_MIN:  i_residuals[i*RES_W +: RES_W] = {1'b1, {BIT_DEPTH{1'b0}}};
				default:  i_residuals[i*RES_W +: RES_W] = '0;
			endcase
		end
		exp_q.push_back(expected_block(i_mode, i_is_inter, i_above, i_left, i_top_right,
			i_bottom_left, i_residuals, i_pred_inter));
		name_q.push_back(name);
		sent++;
	endtask

	// idle until every queued block has come back
	task automatic drain();
		@(negedge clk);
		i_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	always @(negedge clk) begin
		if (o_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("output block arrived while no block was expected");
			end else begin
				exp_blk  = exp_q.pop_front();
				exp_name = name_q.pop_front();
				checked++;
				assert (o_recon == exp_blk) else begin
					errors++;
					$display("ERROR %s: expected %h actual %h", exp_name, exp_blk, o_recon);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles, output blocks did not drain", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(90));
		arst_n        = 1'b0;
		i_valid       = 1'b0;
		i_mode        = MODE_DC;
		i_is_inter    = 1'b0;
		i_above       = '0;
		i_left        = '0;
		i_top_right   = '0;
		i_bottom_left = '0;
		i_residuals   = '0;
		i_pred_inter  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		repeat (2) @(negedge clk);

		for (int m = 0; m < 64; m++) begin
			if (m == 1)
				send_block("dc", mode_t'(m), 1'b0, RES_ZERO);
			else if (m != 0 && m != 10 && m != 26)
				send_block("dc_fallback", mode_t'(m), 1'b0, RES_ZERO);
		end
		drain();

		repeat (16) send_block("vertical", MODE_VER, 1'b0, RES_ZERO);
		repeat (16) send_block("horizontal", MODE_HOR, 1'b0, RES_ZERO);
		drain();

		repeat (24) send_block("planar", MODE_PLANAR, 1'b0, RES_ZERO);
		drain();

		repeat (24) send_block("inter", mode_t'($urandom), 1'b1, RES_RAND);
		drain();

		repeat (4) send_block("clip_high", random_mode(), 1'b0, RES_MAX);
		repeat (4) send_block("clip_high", random_mode(), 1'b1, RES_MAX);
		repeat (4) send_block("clip_low", random_mode(), 1'b0, RES_MIN);
		repeat (4) send_block("clip_low", random_mode(), 1'b1, RES_MIN);
		drain();

		repeat (150) send_block("burst", random_mode(), 1'($urandom), RES_RAND);
		drain();

		if (checked != sent) begin
			errors++;
			$display("%0d blocks were sent but %0d came back", sent, checked);
		end
		$display("blocks sent %0d, checked %0d, errors %0d", sent, checked, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- dv/intra_recon_props.sv
`timescale 1ns/1ps

module intra_recon_props #(
	parameter int BIT_DEPTH = intra_geom_pkg::DEFAULT_BIT_DEPTH
) (
	input logic                                             clk,
	input logic                                             arst_n,
	input logic                                             i_in_valid,
	input logic                                             i_out_valid,
	input logic [intra_geom_pkg::NUM_SAMPLES*BIT_DEPTH-1:0] i_recon
);

	import intra_geom_pkg::*;

	// strobe at edge n shows up at edge n + TOTAL_LATENCY
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		i_in_valid |-> ##TOTAL_LATENCY i_out_valid)
		else $error("o_valid missing %0d cycles after i_valid", TOTAL_LATENCY);

	a_no_spurious: assert property (@(posedge clk) disable iff (!arst_n)
		i_out_valid |-> $past(i_in_valid, TOTAL_LATENCY))
		else $error("o_valid high without a matching i_valid");

	// one reset edge seen before the outputs are expected cleared
	a_reset_state: assert property (@(posedge clk)
		(!arst_n && $past(!arst_n)) |-> (!i_out_valid && i_recon == '0))
		else $error("outputs not cleared during reset");

	// o_recon only moves together with o_valid
	a_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!i_out_valid |-> $stable(i_recon))
		else $error("o_recon changed without o_valid");

endmodule

bind intra_recon_top intra_recon_props #(
	.BIT_DEPTH(BIT_DEPTH)
) u_props (
	.clk        (clk),
	.arst_n     (arst_n),
	.i_in_valid (i_valid),
	.i_out_valid(o_valid),
	.i_recon    (o_recon)
);

//--- design/intra_recon_top.sv
`timescale 1ns/1ps

module intra_recon_top #(
	parameter int BIT_DEPTH = intra_geom_pkg::DEFAULT_BIT_DEPTH
) (
	input  logic                                                 clk,
	input  logic                                                 arst_n,
	input  logic                                                 i_valid,
	input  intra_mode_pkg::mode_t                                i_mode,
	input  logic                                                 i_is_inter,
	input  logic [intra_geom_pkg::TB_SIZE*BIT_DEPTH-1:0]         i_above,
	input  logic [intra_geom_pkg::TB_SIZE*BIT_DEPTH-1:0]         i_left,
	input  logic [BIT_DEPTH-1:0]                                 i_top_right,
	input  logic [BIT_DEPTH-1:0]                                 i_bottom_left,
	input  logic [intra_geom_pkg::NUM_SAMPLES*(BIT_DEPTH+1)-1:0] i_residuals,
	input  logic [intra_geom_pkg::NUM_SAMPLES*BIT_DEPTH-1:0]     i_pred_inter,
	output logic                                                 o_valid,
	output logic [intra_geom_pkg::NUM_SAMPLES*BIT_DEPTH-1:0]     o_recon
);

	import intra_geom_pkg::*;

	// everything that skips the predictor
	typedef struct packed {
		logic                               is_inter;
		logic [NUM_SAMPLES*BIT_DEPTH-1:0]   inter;
		logic [NUM_SAMPLES*(BIT_DEPTH+1)-1:0] residuals;
	} side_t;

	logic                             pred_valid;
	logic [NUM_SAMPLES*BIT_DEPTH-1:0] pred;
	side_t                            side_in;
	side_t                            side_out;

	assign side_in = '{is_inter: i_is_inter, inter: i_pred_inter, residuals: i_residuals};

	intra_pred_4x4 #(
		.BIT_DEPTH(BIT_DEPTH)
	) u_pred (
		.clk          (clk),
		.arst_n       (arst_n),
		.i_valid      (i_valid),
		.i_mode       (i_mode),
		.i_above      (i_above),
		.i_left       (i_left),
		.i_top_right  (i_top_right),
		.i_bottom_left(i_bottom_left),
		.o_pred_valid (pred_valid),
		.o_pred       (pred)
	);

	// same depth as the predictor, so its valid is a copy of pred_valid
	sample_delay #(
		.DEPTH(PRED_LATENCY),
		.T    (side_t)
	) u_side_delay (
		.clk    (clk),
		.arst_n (arst_n),
		.i_valid(i_valid),
		.i_data (side_in),
		.o_valid(),
		.o_data (side_out)
	);

	recon_clip #(
		.BIT_DEPTH(BIT_DEPTH)
	) u_recon (
		.clk         (clk),
		.arst_n      (arst_n),
		.i_valid     (pred_valid),
		.i_is_inter  (side_out.is_inter),
		.i_pred_intra(pred),
		.i_pred_inter(side_out.inter),
		.i_residuals (side_out.residuals),
		.o_valid     (o_valid),
		.o_recon     (o_recon)
	);

endmodule

//--- design/recon_clip.sv
`timescale 1ns/1ps

module recon_clip #(
	parameter int BIT_DEPTH = intra_geom_pkg::DEFAULT_BIT_DEPTH
) (
	input  logic                                                 clk,
	input  logic                                                 arst_n,
	input  logic                                                 i_valid,
	input  logic                                                 i_is_inter,
	input  logic [intra_geom_pkg::NUM_SAMPLES*BIT_DEPTH-1:0]     i_pred_intra,
	input  logic [intra_geom_pkg::NUM_SAMPLES*BIT_DEPTH-1:0]     i_pred_inter,
	input  logic [intra_geom_pkg::NUM_SAMPLES*(BIT_DEPTH+1)-1:0] i_residuals,
	output logic                                                 o_valid,
	output logic [intra_geom_pkg::NUM_SAMPLES*BIT_DEPTH-1:0]     o_recon
);

	import intra_geom_pkg::*;

	localparam int RES_W = BIT_DEPTH + 1;
	localparam int SUM_W = BIT_DEPTH + 2; // pred + signed residual, no overflow

	logic [NUM_SAMPLES*BIT_DEPTH-1:0] recon_next;

	always_comb begin
		logic [BIT_DEPTH-1:0]    pred;
		logic signed [SUM_W-1:0] sum;
		int                      idx;

		for (int y = 0; y < TB_SIZE; y++) begin
			for (int x = 0; x < TB_SIZE; x++) begin
				idx  = y*TB_SIZE + x;
				pred = i_is_inter ? i_pred_inter[idx*BIT_DEPTH +: BIT_DEPTH]
					: i_pred_intra[idx*BIT_DEPTH +: BIT_DEPTH];
				sum  = $signed({2'b00, pred})
					+ SUM_W'($signed(i_residuals[idx*RES_W +: RES_W]));

				if (sum[SUM_W-1])
					recon_next[idx*BIT_DEPTH +: BIT_DEPTH] = '0; // below zero
				else if (sum[BIT_DEPTH])
					recon_next[idx*BIT_DEPTH +: BIT_DEPTH] = '1; // above max sample
				else
					recon_next[idx*BIT_DEPTH +: BIT_DEPTH] = sum[BIT_DEPTH-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			o_valid <= 1'b0;
			o_recon <= '0;
		end else begin
			o_valid <= i_valid;
			if (i_valid)
				o_recon <= recon_next; // held until the next block
		end
	end

endmodule

//--- design/intra_pred_4x4.sv
`timescale 1ns/1ps

module intra_pred_4x4 #(
	parameter int BIT_DEPTH = intra_geom_pkg::DEFAULT_BIT_DEPTH
) (
	input  logic                                             clk,
	input  logic                                             arst_n,
	input  logic                                             i_valid,
	input  intra_mode_pkg::mode_t                            i_mode,
	input  logic [intra_geom_pkg::TB_SIZE*BIT_DEPTH-1:0]     i_above,
	input  logic [intra_geom_pkg::TB_SIZE*BIT_DEPTH-1:0]     i_left,
	input  logic [BIT_DEPTH-1:0]                             i_top_right,
	input  logic [BIT_DEPTH-1:0]                             i_bottom_left,
	output logic                                             o_pred_valid,
	output logic [intra_geom_pkg::NUM_SAMPLES*BIT_DEPTH-1:0] o_pred
);

	import intra_geom_pkg::*;
	import intra_mode_pkg::*;

	// planar and dc sums both fit in BIT_DEPTH+3 bits including rounding
	localparam int SUM_W = BIT_DEPTH + 3;
	localparam int SHIFT = $clog2(TB_SIZE) + 1; // >> 3 for 4x4

	logic [SUM_W-1:0] dc_sum;

	logic                           s1_valid;
	pred_kind_t                     s1_kind;
	logic [TB_SIZE*BIT_DEPTH-1:0]   s1_above;
	logic [TB_SIZE*BIT_DEPTH-1:0]   s1_left;
	logic [BIT_DEPTH-1:0]           s1_top_right;
	logic [BIT_DEPTH-1:0]           s1_bottom_left;
	logic [BIT_DEPTH-1:0]           s1_dc;

	logic [NUM_SAMPLES*BIT_DEPTH-1:0] pred_next;

	// dc: sum of 4 above + 4 left, rounding term folded into the start value
	always_comb begin
		dc_sum = SUM_W'(TB_SIZE);
		for (int i = 0; i < TB_SIZE; i++) begin
			dc_sum = dc_sum + SUM_W'(i_above[i*BIT_DEPTH +: BIT_DEPTH])
				+ SUM_W'(i_left[i*BIT_DEPTH +: BIT_DEPTH]);
		end
	end

	// stage 1
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			s1_kind        <= classify_mode(i_mode);
			s1_above       <= i_above;
			s1_left        <= i_left;
			s1_top_right   <= i_top_right;
			s1_bottom_left <= i_bottom_left;
			s1_dc          <= dc_sum[SHIFT +: BIT_DEPTH];
		end
	end

	// stage 2, all sixteen samples in parallel
	always_comb begin
		logic [SUM_W-1:0]     plan_sum;
		logic [BIT_DEPTH-1:0] above_x;
		logic [BIT_DEPTH-1:0] left_y;
		logic [BIT_DEPTH-1:0] smp;

		for (int y = 0; y < TB_SIZE; y++) begin
			for (int x = 0; x < TB_SIZE; x++) begin
				above_x = s1_above[x*BIT_DEPTH +: BIT_DEPTH];
				left_y  = s1_left[y*BIT_DEPTH +: BIT_DEPTH];

				plan_sum = SUM_W'(TB_SIZE - 1 - x) * left_y
					+ SUM_W'(x + 1) * s1_top_right
					+ SUM_W'(TB_SIZE - 1 - y) * above_x
					+ SUM_W'(y + 1) * s1_bottom_left
					+ SUM_W'(TB_SIZE);

				case (s1_kind)
					PK_PLANAR: smp = plan_sum[SHIFT +: BIT_DEPTH];
					PK_HOR:    smp = left_y;  // row copies left[y]
					PK_VER:    smp = above_x; // column copies above[x]
					default:   smp = s1_dc;
				endcase

				pred_next[(y*TB_SIZE + x)*BIT_DEPTH +: BIT_DEPTH] = smp;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			o_pred_valid <= 1'b0;
		end else begin
			o_pred_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid)
			o_pred <= pred_next;
	end

endmodule

//--- design/sample_delay.sv
`timescale 1ns/1ps

module sample_delay #(
	parameter int  DEPTH = 2,
	parameter type T     = logic
) (
	input  logic clk,
	input  logic arst_n,
	input  logic i_valid,
	input  T     i_data,
	output logic o_valid,
	output T     o_data
);

	logic [DEPTH-1:0] vld;
	T                 data_q [DEPTH];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld <= '0;
		end else begin
			vld[0] <= i_valid;
			for (int k = 1; k < DEPTH; k++)
				vld[k] <= vld[k-1];
		end
	end

	// a stage only moves when a block is actually passing through it
	always_ff @(posedge clk) begin
		if (i_valid)
			data_q[0] <= i_data;
		for (int k = 1; k < DEPTH; k++) begin
			if (vld[k-1])
				data_q[k] <= data_q[k-1];
		end
	end

	assign o_valid = vld[DEPTH-1];
	assign o_data  = data_q[DEPTH-1];

endmodule

//--- design/intra_mode_pkg.sv
package intra_mode_pkg;

	typedef logic [5:0] mode_t; // hevc intra mode code

	localparam mode_t MODE_PLANAR = 6'd0;
	localparam mode_t MODE_DC     = 6'd1;
	localparam mode_t MODE_HOR    = 6'd10;
	localparam mode_t MODE_VER    = 6'd26;

	// what the predictor actually builds
	typedef enum logic [1:0] {
		PK_PLANAR = 2'd0,
		PK_DC     = 2'd1,
		PK_HOR    = 2'd2,
		PK_VER    = 2'd3
	} pred_kind_t;

	// angular codes other than 10/26 have no datapath here, they fall back to dc
	function automatic pred_kind_t classify_mode(input mode_t mode);
		case (mode)
			MODE_PLANAR: return PK_PLANAR;
			MODE_DC:     return PK_DC;
			MODE_HOR:    return PK_HOR;
			MODE_VER:    return PK_VER;
			default:     return PK_DC;
		endcase
	endfunction

endpackage

//--- design/intra_geom_pkg.sv
package intra_geom_pkg;

	// one luma transform block, 4x4 only
	localparam int TB_SIZE = 4;

	// samples per block, raster order y*TB_SIZE + x
	localparam int NUM_SAMPLES = TB_SIZE * TB_SIZE;

	localparam int DEFAULT_BIT_DEPTH = 8;

	// predictor depth in cycles
	// the side path (residuals, inter samples) is delayed by the same amount
	localparam int PRED_LATENCY = 2;

	// full pipeline, predictor plus the recon register
	localparam int TOTAL_LATENCY = PRED_LATENCY + 1;

endpackage
